/* hw/led_driver_pkg.sv */
package led_driver_pkg;

    // Driver FSM states
    typedef enum logic [3:0] {
        STALL,
        PREPARE_CONFIG,
        CONFIG,
        WRTFC_TIMING,
        PREPARE_DUMP_CONFIG,
        DUMP_CONFIG,
        WAIT_FOR_NEXT_SLICE,
        BLANKING,
        PAUSE_SCLK,
        SHIFT_REGISTER
    } drv_state_e;

    // Driver chain size
    localparam int NUM_DRIVERS = 3;
    // One config word or one GS shift burst
    localparam int WORD_BITS = 48;

    // Slice geometry
    localparam int GS_PLANES = 9;
    localparam int MUX_LINES = 8;
    localparam int SLICE_WORDS = GS_PLANES * MUX_LINES;

    // Dark time before each multiplexed line
    localparam int BLANKING_TIME = 72;

    // LAT command lengths in SCLK edges
    localparam int FCWRTEN_LEN = 15;
    localparam int WRTFC_LEN = 5;
    localparam int READFC_LEN = 11;
    localparam int LATGS_LEN = 3;
    localparam int WRTGS_LEN = 1;

    // Gap after WRTFC before READFC
    localparam int WRTFC_WAIT = 6;
    // SCLK held low after READFC
    localparam int DUMP_WAIT = 5;

    // Board routing of the LED outputs, one group per driver
    // Red and green channels
    localparam logic [3:0] LUT_RG [0:NUM_DRIVERS-1][0:15] = '{
        '{4'd6, 4'd7, 4'd9, 4'd8, 4'd10, 4'd11, 4'd13, 4'd12,
          4'd14, 4'd15, 4'd1, 4'd0, 4'd2, 4'd3, 4'd5, 4'd4},
        '{4'd2, 4'd3, 4'd5, 4'd4, 4'd6, 4'd7, 4'd9, 4'd8,
          4'd10, 4'd11, 4'd13, 4'd12, 4'd14, 4'd15, 4'd1, 4'd0},
        '{4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9,
          4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd15, 4'd0, 4'd1}
    };

    // Blue channel
    localparam logic [3:0] LUT_B [0:NUM_DRIVERS-1][0:15] = '{
        '{4'd8, 4'd9, 4'd14, 4'd15, 4'd12, 4'd13, 4'd2, 4'd3,
          4'd0, 4'd1, 4'd6, 4'd7, 4'd4, 4'd5, 4'd10, 4'd11},
        '{4'd0, 4'd1, 4'd6, 4'd7, 4'd4, 4'd5, 4'd9, 4'd11,
          4'd8, 4'd10, 4'd14, 4'd15, 4'd12, 4'd13, 4'd2, 4'd3},
        '{4'd1, 4'd0, 4'd6, 4'd7, 4'd5, 4'd4, 4'd8, 4'd11,
          4'd9, 4'd10, 4'd14, 4'd15, 4'd13, 4'd12, 4'd2, 4'd3}
    };

endpackage

/* hw/frame_store.sv */
`timescale 1ns/1ns

module frame_store (
    input  logic        clk,
    input  logic        nrst,

    // Host write port
    input  logic        wr_en,
    input  logic [1:0]  wr_drv,
    input  logic [6:0]  wr_addr,
    input  logic [47:0] wr_data,

    // Pointer control from the sequencer
    input  logic        slice_start,
    input  logic        driver_ready,

    // Current burst word for every driver
    output logic [led_driver_pkg::WORD_BITS-1:0] pixel_words [led_driver_pkg::NUM_DRIVERS]
);
    import led_driver_pkg::*;

    // One slice worth of words per driver
    logic [WORD_BITS-1:0] mem [NUM_DRIVERS][SLICE_WORDS];
    logic [6:0]           rd_ptr;

    // Host writes, out of range slots ignored
    always_ff @(posedge clk) begin
        if (wr_en && wr_drv < 2'(NUM_DRIVERS) && wr_addr < 7'(SLICE_WORDS)) begin
            mem[wr_drv][wr_addr] <= wr_data;
        end
    end

    // Read pointer, one step per finished burst
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_ptr <= '0;
        end else if (slice_start) begin
            rd_ptr <= '0;
        end else if (driver_ready) begin
            // Wrap after the last plane of the last line
            if (rd_ptr == 7'(SLICE_WORDS - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 7'd1;
            end
        end
    end

    // Asynchronous read so the word is valid during PAUSE_SCLK
    always_comb begin
        for (int d = 0; d < NUM_DRIVERS; d++) begin
            pixel_words[d] = mem[d][rd_ptr];
        end
    end

endmodule

/* hw/driver_sequencer.sv */
`timescale 1ns/1ns

module driver_sequencer (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       clk_enable,

    // Rotor position and host config strobes
    input  logic                       position_sync,
    input  logic                       new_configuration_ready,

    // FSM state and counters for the pin blocks
    output led_driver_pkg::drv_state_e state,
    output logic [9:0]                 state_cnt,
    output logic [3:0]                 wrtgs_cnt,
    output logic [3:0]                 led_idx,
    output logic [1:0]                 rgb_idx,

    // Gated driver clocks
    output logic                       driver_sclk,
    output logic                       driver_gclk,

    // Strobes
    output logic                       slice_start,
    output logic                       driver_ready,
    output logic                       column_ready
);
    import led_driver_pkg::*;

    // Current multiplexed line
    logic [2:0] mux_cnt;
    logic       streaming;
    logic       burst_end;

    // States a reconfiguration may interrupt
    assign streaming = state == BLANKING || state == WAIT_FOR_NEXT_SLICE
                    || state == PAUSE_SCLK || state == SHIFT_REGISTER;

    // Last bit of a GS burst
    assign burst_end = state == SHIFT_REGISTER && state_cnt == 10'(WORD_BITS - 1);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= STALL;
            state_cnt <= '0;
            wrtgs_cnt <= '0;
            mux_cnt   <= '0;
            led_idx   <= '0;
            rgb_idx   <= '0;
        end else if (clk_enable) begin
            case (state)
                STALL: begin
                    state <= PREPARE_CONFIG;
                end

                // FCWRTEN command with LAT high
                PREPARE_CONFIG: begin
                    state_cnt <= state_cnt + 10'd1;
                    if (state_cnt == 10'(FCWRTEN_LEN - 1)) begin
                        state     <= CONFIG;
                        state_cnt <= '0;
                    end
                end

                // One idle cycle then the 48 config bits
                CONFIG: begin
                    state_cnt <= state_cnt + 10'd1;
                    if (state_cnt == 10'(WORD_BITS)) begin
                        state     <= WRTFC_TIMING;
                        state_cnt <= '0;
                    end
                end

                // Settle time after WRTFC
                WRTFC_TIMING: begin
                    state_cnt <= state_cnt + 10'd1;
                    if (state_cnt == 10'(WRTFC_WAIT - 1)) begin
                        state     <= PREPARE_DUMP_CONFIG;
                        state_cnt <= '0;
                    end
                end

                // READFC command
                PREPARE_DUMP_CONFIG: begin
                    state_cnt <= state_cnt + 10'd1;
                    if (state_cnt == 10'(READFC_LEN - 1)) begin
                        state     <= DUMP_CONFIG;
                        state_cnt <= '0;
                    end
                end

                // Config read-back on SOUT, not captured here
                DUMP_CONFIG: begin
                    state_cnt <= state_cnt + 10'd1;
                    if (state_cnt == 10'(DUMP_WAIT + WORD_BITS - 1)) begin
                        state     <= WAIT_FOR_NEXT_SLICE;
                        state_cnt <= '0;
                    end
                end

                WAIT_FOR_NEXT_SLICE: begin
                    mux_cnt <= '0;
                    // Counter only marks the entry cycle
                    if (state_cnt == '0) begin
                        state_cnt <= 10'd1;
                    end
                    if (position_sync) begin
                        state     <= BLANKING;
                        state_cnt <= '0;
                    end
                end

                BLANKING: begin
                    wrtgs_cnt <= '0;
                    led_idx   <= '0;
                    rgb_idx   <= '0;
                    state_cnt <= state_cnt + 10'd1;
                    if (state_cnt == 10'(BLANKING_TIME - 1)) begin
                        state     <= PAUSE_SCLK;
                        state_cnt <= '0;
                    end
                end

                // One cycle for the frame store to present the next word
                PAUSE_SCLK: begin
                    state <= SHIFT_REGISTER;
                end

                SHIFT_REGISTER: begin
                    state_cnt <= state_cnt + 10'd1;
                    if (burst_end) begin
                        state_cnt <= '0;
                        wrtgs_cnt <= wrtgs_cnt + 4'd1;
                        state     <= PAUSE_SCLK;
                        // Last plane closes the line
                        if (wrtgs_cnt == 4'(GS_PLANES - 1)) begin
                            wrtgs_cnt <= '0;
                            mux_cnt   <= mux_cnt + 3'd1;
                            state     <= BLANKING;
                            if (mux_cnt == 3'(MUX_LINES - 1)) begin
                                mux_cnt <= '0;
                                state   <= WAIT_FOR_NEXT_SLICE;
                            end
                        end
                    end
                    // Colour steps fastest, 16 LEDs of 3 colours per burst
                    rgb_idx <= rgb_idx + 2'd1;
                    if (rgb_idx == 2'd2) begin
                        rgb_idx <= '0;
                        led_idx <= led_idx + 4'd1;
                    end
                end

                default: begin
                    state     <= STALL;
                    state_cnt <= '0;
                end
            endcase

            // Host reconfig restarts the boot sequence
            if (new_configuration_ready && streaming) begin
                state     <= PREPARE_CONFIG;
                state_cnt <= '0;
                wrtgs_cnt <= '0;
                mux_cnt   <= '0;
                led_idx   <= '0;
                rgb_idx   <= '0;
            end
        end
    end

    // SCLK runs with the latch commands and the shifted bits
    always_comb begin
        case (state)
            PREPARE_CONFIG, PREPARE_DUMP_CONFIG, SHIFT_REGISTER: begin
                driver_sclk = clk_enable;
            end
            CONFIG: begin
                driver_sclk = clk_enable && state_cnt != '0;
            end
            DUMP_CONFIG: begin
                driver_sclk = clk_enable && state_cnt >= 10'(DUMP_WAIT);
            end
            default: begin
                driver_sclk = 1'b0;
            end
        endcase
    end

    // GCLK only once GS data is latched, idle during configuration
    always_comb begin
        case (state)
            WAIT_FOR_NEXT_SLICE: begin
                driver_gclk = clk_enable && state_cnt != '0;
            end
            BLANKING: begin
                driver_gclk = clk_enable && state_cnt != '0 && mux_cnt != '0;
            end
            PAUSE_SCLK, SHIFT_REGISTER: begin
                driver_gclk = clk_enable;
            end
            default: begin
                driver_gclk = 1'b0;
            end
        endcase
    end

    assign slice_start  = clk_enable && state == WAIT_FOR_NEXT_SLICE && position_sync
                       && !new_configuration_ready;
    assign driver_ready = clk_enable && burst_end;
    assign column_ready = clk_enable && burst_end && wrtgs_cnt == 4'(GS_PLANES - 1);

endmodule

/* hw/gs_bit_mapper.sv */
`timescale 1ns/1ns

module gs_bit_mapper (
    input  led_driver_pkg::drv_state_e state,
    input  logic [9:0]                 state_cnt,
    input  logic [3:0]                 led_idx,
    input  logic [1:0]                 rgb_idx,

    // Configuration word shared by all drivers
    input  logic [47:0]                serialized_conf,
    // Burst word per driver
    input  logic [led_driver_pkg::WORD_BITS-1:0] pixel_words [led_driver_pkg::NUM_DRIVERS],

    output logic [led_driver_pkg::NUM_DRIVERS-1:0] drivers_sin
);
    import led_driver_pkg::*;

    logic [5:0] conf_idx;
    logic [3:0] lut_row;
    logic [3:0] lut_entry [NUM_DRIVERS];
    logic [5:0] src_idx [NUM_DRIVERS];

    // Config goes out MSB first after the idle cycle
    assign conf_idx = 6'(10'(WORD_BITS) - state_cnt);

    // LEDs are shifted from the last output down
    assign lut_row = 4'd15 - led_idx;

    // Source bit per driver from its routing group
    always_comb begin
        for (int d = 0; d < NUM_DRIVERS; d++) begin
            // Blue uses its own table
            if (rgb_idx == 2'd0) begin
                lut_entry[d] = LUT_B[d][lut_row];
            end else begin
                lut_entry[d] = LUT_RG[d][lut_row];
            end
            src_idx[d] = 6'd3 * {2'b00, lut_entry[d]} + 6'd2 - {4'b0000, rgb_idx};
        end
    end

    always_comb begin
        drivers_sin = '0;
        case (state)
            CONFIG: begin
                // Count 0 is the pause after FCWRTEN
                if (state_cnt != '0) begin
                    drivers_sin = {NUM_DRIVERS{serialized_conf[conf_idx]}};
                end
            end
            SHIFT_REGISTER: begin
                for (int d = 0; d < NUM_DRIVERS; d++) begin
                    drivers_sin[d] = pixel_words[d][src_idx[d]];
                end
            end
            default: begin
                drivers_sin = '0;
            end
        endcase
    end

endmodule

/* hw/lat_generator.sv */
`timescale 1ns/1ns

module lat_generator (
    input  logic                       clk,
    input  logic                       nrst,
    input  led_driver_pkg::drv_state_e state,
    input  logic [9:0]                 state_cnt,
    input  logic [3:0]                 wrtgs_cnt,
    output logic                       driver_lat
);
    import led_driver_pkg::*;

    logic wrtfc_window;
    logic wrtgs_window;
    logic latgs_window;

    // WRTFC on the last config bits
    assign wrtfc_window = state_cnt >= 10'(WORD_BITS + 1 - WRTFC_LEN);

    // WRTGS closes every plane
    assign wrtgs_window = state_cnt >= 10'(WORD_BITS - WRTGS_LEN);

    // LATGS on the last plane of a line
    assign latgs_window = wrtgs_cnt == 4'(GS_PLANES - 1)
                       && state_cnt >= 10'(WORD_BITS - LATGS_LEN);

    // Falling edge gives hold time after the SCLK rising edge
    always_ff @(negedge clk or negedge nrst) begin
        if (!nrst) begin
            driver_lat <= 1'b0;
        end else begin
            case (state)
                // FCWRTEN and READFC span the whole state
                PREPARE_CONFIG, PREPARE_DUMP_CONFIG: begin
                    driver_lat <= 1'b1;
                end
                CONFIG: begin
                    driver_lat <= wrtfc_window;
                end
                SHIFT_REGISTER: begin
                    driver_lat <= wrtgs_window || latgs_window;
                end
                default: begin
                    driver_lat <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* hw/led_driver_top.sv */
`timescale 1ns/1ns

module led_driver_top (
    input  logic        clk,
    input  logic        nrst,
    input  logic        clk_enable,

    // Rotor and host control
    input  logic        position_sync,
    input  logic        new_configuration_ready,
    input  logic [47:0] serialized_conf,

    // Frame store write port
    input  logic        wr_en,
    input  logic [1:0]  wr_drv,
    input  logic [6:0]  wr_addr,
    input  logic [47:0] wr_data,

    // Driver pins
    output logic        driver_sclk,
    output logic        driver_gclk,
    output logic        driver_lat,
    output logic [led_driver_pkg::NUM_DRIVERS-1:0] drivers_sin,

    // Status strobes
    output logic        driver_ready,
    output logic        column_ready
);
    import led_driver_pkg::*;

    drv_state_e           state;
    logic [9:0]           state_cnt;
    logic [3:0]           wrtgs_cnt;
    logic [3:0]           led_idx;
    logic [1:0]           rgb_idx;
    logic                 slice_start;
    logic [WORD_BITS-1:0] pixel_words [NUM_DRIVERS];

    // Slice words, one pointer step per burst
    frame_store frame_store_i (
        .clk          (clk),
        .nrst         (nrst),
        .wr_en        (wr_en),
        .wr_drv       (wr_drv),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .slice_start  (slice_start),
        .driver_ready (driver_ready),
        .pixel_words  (pixel_words)
    );

    // Main FSM with clock gating
    driver_sequencer driver_sequencer_i (
        .clk                     (clk),
        .nrst                    (nrst),
        .clk_enable              (clk_enable),
        .position_sync           (position_sync),
        .new_configuration_ready (new_configuration_ready),
        .state                   (state),
        .state_cnt               (state_cnt),
        .wrtgs_cnt               (wrtgs_cnt),
        .led_idx                 (led_idx),
        .rgb_idx                 (rgb_idx),
        .driver_sclk             (driver_sclk),
        .driver_gclk             (driver_gclk),
        .slice_start             (slice_start),
        .driver_ready            (driver_ready),
        .column_ready            (column_ready)
    );

    // Serial data per driver
    gs_bit_mapper gs_bit_mapper_i (
        .state           (state),
        .state_cnt       (state_cnt),
        .led_idx         (led_idx),
        .rgb_idx         (rgb_idx),
        .serialized_conf (serialized_conf),
        .pixel_words     (pixel_words),
        .drivers_sin     (drivers_sin)
    );

    // Latch commands
    lat_generator lat_generator_i (
        .clk        (clk),
        .nrst       (nrst),
        .state      (state),
        .state_cnt  (state_cnt),
        .wrtgs_cnt  (wrtgs_cnt),
        .driver_lat (driver_lat)
    );

endmodule

/* verification/led_driver_tb.sv */
`timescale 1ns/1ns

module led_driver_tb;
    import led_driver_pkg::*;

    // Clock and cycle budgets in enabled cycles
    localparam int CLK_PERIOD = 20;
    localparam int SLICE_CYCLES = MUX_LINES * (BLANKING_TIME + GS_PLANES * (WORD_BITS + 1));
    localparam int BOOT_CYCLES = 1 + FCWRTEN_LEN + WORD_BITS + 1 + WRTFC_WAIT + READFC_LEN
                               + DUMP_WAIT + WORD_BITS;
    localparam int STORE_CYCLES = NUM_DRIVERS * SLICE_WORDS + 1;
    // FCWRTEN, config bits, READFC, read-back
    localparam int BOOT_SCLKS = FCWRTEN_LEN + WORD_BITS + READFC_LEN + WORD_BITS;
    // No GCLK on line 0 blanking nor on the first cycle of later blankings
    localparam int SLICE_GCLKS = (MUX_LINES - 1) * (BLANKING_TIME - 1)
                               + SLICE_WORDS * (WORD_BITS + 1);
    localparam int NUM_CASES = 4;

    // Conf word, enable gaps, slices, reconfig line (-1 for none)
    typedef struct packed {
        logic [47:0] conf;
        logic        gaps;
        int          slices;
        int          reconf_line;
    } case_row_t;

    localparam case_row_t CASES [NUM_CASES] = '{
        '{48'hA5C3_0F96_1E2D, 1'b0, 2, -1},
        '{48'h1234_5678_9ABC, 1'b1, 2, -1},
        '{48'hFEDC_BA98_7654, 1'b0, 1, 3},
        '{48'h0F0F_F0F0_3C3C, 1'b1, 1, 5}
    };

    logic                   clk = 1'b0;
    logic                   nrst;
    logic                   clk_enable = 1'b1;
    logic                   position_sync;
    logic                   new_configuration_ready;
    logic [47:0]            serialized_conf;
    logic                   wr_en;
    logic [1:0]             wr_drv;
    logic [6:0]             wr_addr;
    logic [47:0]            wr_data;
    logic                   driver_sclk;
    logic                   driver_gclk;
    logic                   driver_lat;
    logic [NUM_DRIVERS-1:0] drivers_sin;
    logic                   driver_ready;
    logic                   column_ready;

    // Copy of what the host wrote
    logic [WORD_BITS-1:0] store [NUM_DRIVERS][SLICE_WORDS];
    logic                 gaps_on = 1'b0;

    // Monitor state, only ever counts up
    int sclk_cnt = 0;
    int ready_cnt = 0;
    int col_cnt = 0;
    int gclk_cnt = 0;
    int run_len = 0;
    logic [WORD_BITS-1:0] sreg [NUM_DRIVERS];
    int lat_runs [$];
    logic [NUM_DRIVERS*WORD_BITS-1:0] lat_words [$];

    // Counter values at the start of a phase
    int sclk_base;
    int ready_base;
    int col_base;
    int gclk_base;
    int run_base;

    led_driver_top led_driver_top_i (
        .clk                     (clk),
        .nrst                    (nrst),
        .clk_enable              (clk_enable),
        .position_sync           (position_sync),
        .new_configuration_ready (new_configuration_ready),
        .serialized_conf         (serialized_conf),
        .wr_en                   (wr_en),
        .wr_drv                  (wr_drv),
        .wr_addr                 (wr_addr),
        .wr_data                 (wr_data),
        .driver_sclk             (driver_sclk),
        .driver_gclk             (driver_gclk),
        .driver_lat              (driver_lat),
        .drivers_sin             (drivers_sin),
        .driver_ready            (driver_ready),
        .column_ready            (column_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Roughly one disabled cycle in four when gaps are on
    always @(negedge clk) begin
        if (gaps_on) begin
            clk_enable = ($urandom % 4) != 0;
        end else begin
            clk_enable = 1'b1;
        end
    end

    // Pin monitor, samples just before the DUT updates
    always @(posedge clk) begin
        logic [NUM_DRIVERS*WORD_BITS-1:0] snap;
        if (nrst) begin
            if (driver_sclk) begin
                sclk_cnt++;
                for (int d = 0; d < NUM_DRIVERS; d++) begin
                    sreg[d] = {sreg[d][WORD_BITS-2:0], drivers_sin[d]};
                end
            end
            if (driver_ready) ready_cnt++;
            if (column_ready) col_cnt++;
            if (driver_gclk) gclk_cnt++;
            // LAT length counts enabled cycles only
            if (driver_lat) begin
                if (clk_enable) run_len++;
            end else if (run_len != 0) begin
                // Shift words are complete when LAT drops
                for (int d = 0; d < NUM_DRIVERS; d++) begin
                    snap[d*WORD_BITS +: WORD_BITS] = sreg[d];
                end
                lat_runs.push_back(run_len);
                lat_words.push_back(snap);
                run_len = 0;
            end
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Errors found");
        $fatal(1, "wait limit exceeded");
    endtask

    // Expected shift word of driver d, first bit out lands in the MSB
    function automatic logic [WORD_BITS-1:0] lut_order(input int d,
                                                       input logic [WORD_BITS-1:0] word);
        logic [WORD_BITS-1:0] res;
        int led;
        int rgb;
        int src;
        for (int k = 0; k < WORD_BITS; k++) begin
            led = k / 3;
            rgb = k % 3;
            if (rgb == 0) begin
                src = 3 * int'(LUT_B[d][15 - led]) + 2 - rgb;
            end else begin
                src = 3 * int'(LUT_RG[d][15 - led]) + 2 - rgb;
            end
            res[WORD_BITS - 1 - k] = word[src];
        end
        return res;
    endfunction

    task automatic clear_monitors();
        sclk_base  = sclk_cnt;
        ready_base = ready_cnt;
        col_base   = col_cnt;
        gclk_base  = gclk_cnt;
        run_base   = lat_runs.size();
    endtask

    // Fresh random words for every slot of the slice
    task automatic fill_store();
        logic [63:0] rnd;
        for (int d = 0; d < NUM_DRIVERS; d++) begin
            for (int a = 0; a < SLICE_WORDS; a++) begin
                @(negedge clk);
                rnd = {$urandom, $urandom};
                store[d][a] = rnd[WORD_BITS-1:0];
                wr_en   = 1'b1;
                wr_drv  = 2'(d);
                wr_addr = 7'(a);
                wr_data = rnd[WORD_BITS-1:0];
            end
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // Strobe held until an enabled edge takes it
    task automatic send_reconfig(input logic [47:0] conf);
        @(negedge clk);
        serialized_conf = conf;
        new_configuration_ready = 1'b1;
        @(posedge clk);
        while (!clk_enable) @(posedge clk);
        @(negedge clk);
        new_configuration_ready = 1'b0;
        clear_monitors();
    endtask

    // GCLK of the slice counts from the edge after the sync is taken
    task automatic start_slice();
        @(negedge clk);
        position_sync = 1'b1;
        @(posedge clk);
        while (!clk_enable) @(posedge clk);
        @(negedge clk);
        position_sync = 1'b0;
        gclk_base = gclk_cnt;
    endtask

    // Extra edge at the end lets the last LAT run close
    task automatic wait_columns(input int target);
        int n;
        n = 0;
        while (col_cnt - col_base < target) begin
            if (n > 3 * SLICE_CYCLES) timed_out("column_ready pulses");
            @(negedge clk);
            n++;
        end
        @(negedge clk);
    endtask

    // GCLK restarts only in WAIT_FOR_NEXT_SLICE
    task automatic wait_gclk();
        int n;
        n = 0;
        while (gclk_cnt == gclk_base) begin
            if (n > 3 * BOOT_CYCLES) timed_out("the end of the boot sequence");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic expect_boot(input logic [47:0] conf);
        logic [NUM_DRIVERS*WORD_BITS-1:0] snap;
        wait_gclk();
        check_value("driver_lat boot runs", 64'(3), 64'(lat_runs.size() - run_base));
        check_value("driver_lat FCWRTEN length", 64'(FCWRTEN_LEN), 64'(lat_runs[run_base]));
        check_value("driver_lat WRTFC length", 64'(WRTFC_LEN), 64'(lat_runs[run_base + 1]));
        check_value("driver_lat READFC length", 64'(READFC_LEN), 64'(lat_runs[run_base + 2]));
        // Config bits sit in the shift register when WRTFC ends
        snap = lat_words[run_base + 1];
        for (int d = 0; d < NUM_DRIVERS; d++) begin
            check_value($sformatf("drivers_sin[%0d] config word", d), 64'(conf),
                        64'(snap[d*WORD_BITS +: WORD_BITS]));
        end
        check_value("driver_sclk boot pulses", 64'(BOOT_SCLKS), 64'(sclk_cnt - sclk_base));
        check_value("driver_ready during boot", 64'(0), 64'(ready_cnt - ready_base));
    endtask

    task automatic expect_slice();
        logic [NUM_DRIVERS*WORD_BITS-1:0] snap;
        int exp_len;
        check_value("driver_ready pulses", 64'(SLICE_WORDS), 64'(ready_cnt - ready_base));
        check_value("column_ready pulses", 64'(MUX_LINES), 64'(col_cnt - col_base));
        check_value("driver_sclk pulses", 64'(SLICE_WORDS * WORD_BITS), 64'(sclk_cnt - sclk_base));
        check_value("driver_gclk pulses", 64'(SLICE_GCLKS), 64'(gclk_cnt - gclk_base));
        check_value("driver_lat runs", 64'(SLICE_WORDS), 64'(lat_runs.size() - run_base));
        for (int i = 0; i < SLICE_WORDS; i++) begin
            // LATGS closes the last plane of each line
            exp_len = (i % GS_PLANES == GS_PLANES - 1) ? LATGS_LEN : WRTGS_LEN;
            check_value($sformatf("driver_lat run %0d length", i), 64'(exp_len),
                        64'(lat_runs[run_base + i]));
            snap = lat_words[run_base + i];
            for (int d = 0; d < NUM_DRIVERS; d++) begin
                check_value($sformatf("drivers_sin[%0d] burst %0d", d, i),
                            64'(lut_order(d, store[d][i])), 64'(snap[d*WORD_BITS +: WORD_BITS]));
            end
        end
    endtask

    // Watchdog sized from the table, three times the nominal length
    initial begin
        int limit;
        limit = 0;
        for (int r = 0; r < NUM_CASES; r++) begin
            limit += (CASES[r].slices + (CASES[r].reconf_line >= 0 ? 1 : 0))
                   * (SLICE_CYCLES + STORE_CYCLES) + 2 * BOOT_CYCLES;
        end
        limit = limit * 3 + 5000;
        #(limit * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the DUT stopped making progress", limit);
        $display("Errors found");
        $fatal(1, "watchdog");
    end

    initial begin
        logic [47:0] new_conf;
        void'($urandom(32'h6bb6_27b8));
        nrst = 1'b0;
        position_sync = 1'b0;
        new_configuration_ready = 1'b0;
        serialized_conf = CASES[0].conf;
        wr_en = 1'b0;
        wr_drv = '0;
        wr_addr = '0;
        wr_data = '0;
        gaps_on = CASES[0].gaps;

        // All pins quiet while in reset
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_value("driver_sclk in reset", 64'(0), 64'(driver_sclk));
            check_value("driver_gclk in reset", 64'(0), 64'(driver_gclk));
            check_value("driver_lat in reset", 64'(0), 64'(driver_lat));
            check_value("drivers_sin in reset", 64'(0), 64'(drivers_sin));
            check_value("driver_ready in reset", 64'(0), 64'(driver_ready));
            check_value("column_ready in reset", 64'(0), 64'(column_ready));
        end
        nrst = 1'b1;
        clear_monitors();

        for (int r = 0; r < NUM_CASES; r++) begin
            gaps_on = CASES[r].gaps;
            // First row boots from reset, later ones by reconfig
            if (r != 0) send_reconfig(CASES[r].conf);
            expect_boot(CASES[r].conf);
            for (int s = 0; s < CASES[r].slices; s++) begin
                fill_store();
                clear_monitors();
                start_slice();
                if (s == 0 && CASES[r].reconf_line >= 0) begin
                    // Abort mid-slice, boot again, then restart from address 0
                    wait_columns(CASES[r].reconf_line);
                    check_value("driver_ready before reconfig",
                                64'(GS_PLANES * CASES[r].reconf_line),
                                64'(ready_cnt - ready_base));
                    new_conf = ~CASES[r].conf;
                    send_reconfig(new_conf);
                    expect_boot(new_conf);
                    fill_store();
                    clear_monitors();
                    start_slice();
                end
                wait_columns(MUX_LINES);
                expect_slice();
            end
        end

        $display("No errors");
        $finish;
    end

endmodule

/* tb.f */
hw/led_driver_pkg.sv
hw/frame_store.sv
hw/driver_sequencer.sv
hw/gs_bit_mapper.sv
hw/lat_generator.sv
hw/led_driver_top.sv
verification/led_driver_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LED driver testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module led_driver_tb -Mdir obj_dir -f tb.f &&
    ./obj_dir/Vled_driver_tb > sim.log 2>&1 ||
    echo "Build or simulation stopped with an error"

cat sim.log 2>/dev/null
# Only the pass line in the log counts as success
grep -qx "No errors" sim.log && echo "Simulation passed" && exit 0 ||
    { echo "Simulation failed"; exit 1; }
